// File: files.f
verilog/vector_pkg.sv
verilog/scheduler.sv
verilog/v_cu.sv
verilog/m_cu.sv
verilog/vector_issue_top.sv
verif/vector_issue_sva.sv
verif/vector_issue_tb.sv

// File: Bender.yml
package:
  name: vector_issue

sources:
  - files:
      - verilog/vector_pkg.sv
      - verilog/scheduler.sv
      - verilog/v_cu.sv
      - verilog/m_cu.sv
      - verilog/vector_issue_top.sv
  - target: simulation
    files:
      - verif/vector_issue_sva.sv
      - verif/vector_issue_tb.sv

// File: verif/vector_issue_tb.sv
// testbench for the vector issue front end
// random instruction stimulus, reference decode, issue and memory scoreboards
`timescale 1ns/1ps
`default_nettype none

module vector_issue_tb;

   import vector_pkg::*;

   localparam int EXEC_LAT   = 3;
   localparam int VLEN_ELEMS = 4;
   localparam int N_ARITH    = 24;
   localparam int N_B2B      = 8;
   // instructions plus trailing bubbles, a split load takes three slots
   localparam int N_SLOTS    = 2 * N_ARITH + 8 + 4 * 3 + 2 + N_B2B + 1;
   localparam int MAX_CYCLES = N_SLOTS * (EXEC_LAT + VLEN_ELEMS + 8) + 16;

   logic        clk = 1'b0;
   logic        rstn;
   word_t       vector_instr_i;
   word_t       rs1_i;
   word_t       rs2_i;
   sew_t        sew_i;
   logic        vector_stall_o;
   logic        issue_vld_o;
   logic [3:0]  issue_lane_o;
   word_t       issue_instr_o;
   word_t       issue_rs1_o;
   logic        mem_req_o;
   logic        mem_we_o;
   word_t       mem_addr_o;

   // scoreboards
   int          exp_lane[$];
   word_t       exp_instr[$];
   word_t       exp_rs1[$];
   logic [32:0] exp_mem[$];
   int          load_marks[$];
   int          reads_pushed = 0;
   int          reads_seen = 0;
   int          issues_seen = 0;
   int          mem_seen = 0;
   int          errors = 0;
   int          cycles;

   always #2 clk = ~clk;

   vector_issue_top #(.EXEC_LAT(EXEC_LAT), .VLEN_ELEMS(VLEN_ELEMS)) u_vector_issue_top
   (
      .clk            (clk),
      .rstn           (rstn),
      .vector_instr_i (vector_instr_i),
      .rs1_i          (rs1_i),
      .rs2_i          (rs2_i),
      .sew_i          (sew_i),
      .vector_stall_o (vector_stall_o),
      .issue_vld_o    (issue_vld_o),
      .issue_lane_o   (issue_lane_o),
      .issue_instr_o  (issue_instr_o),
      .issue_rs1_o    (issue_rs1_o),
      .mem_req_o      (mem_req_o),
      .mem_we_o       (mem_we_o),
      .mem_addr_o     (mem_addr_o)
   );

   // lane number for an instruction, -1 when nothing issues
   function automatic int expected_lane(input word_t ins);
      logic [6:0] op;
      logic [2:0] f3;
      logic [5:0] f6;
      logic       by_mcu;
      op     = ins[6:0];
      f3     = ins[14:12];
      f6     = ins[31:26];
      by_mcu = (ins[27:26] == unit_stride) || (ins[27:26] == strided);
      if (op == v_st_opcode)
         return by_mcu ? 2 : 3;
      if (op == v_ld_opcode)
         return by_mcu ? 4 : 5;
      if (op != v_arith_opcode)
         return -1;
      if (f3 != OPCFG && f6[5:1] == 5'b00111)
         return 12;
      case (f3)
         OPIVV:   return 0;
         OPIVI:   return 1;
         OPIVX:   return 6;
         OPMVV:   return (f6[5:3] == 3'b101) ? 9 : 7;
         OPMVX:   return (f6[5:3] == 3'b101) ? 10 : 8;
         OPCFG:   return 11;
         default: return -1;
      endcase
   endfunction

   function automatic word_t elem_size(input width_t w);
      case (w)
         3'b101:  return 32'd2;
         3'b110:  return 32'd4;
         3'b111:  return 32'd8;
         default: return 32'd1;
      endcase
   endfunction

   function automatic width_t load_width(input sew_t s);
      width_t codes[4];
      codes = '{3'd0, 3'd5, 3'd6, 3'd7};
      return codes[s];
   endfunction

   function automatic word_t random_arith();
      int         kind;
      logic [2:0] lo;
      word_t      ins;
      kind = $urandom_range(0, 8);
      lo   = 3'($urandom);
      ins  = $urandom;
      ins[6:0]   = v_arith_opcode;
      ins[31:26] = {3'b010, lo};
      case (kind)
         0: ins[14:12] = OPIVV;
         1: ins[14:12] = OPIVI;
         2: ins[14:12] = OPIVX;
         3: ins[14:12] = OPMVV;
         4: ins[14:12] = OPMVX;
         5:
         begin
            ins[14:12] = OPMVV;
            ins[31:26] = {3'b101, lo};
         end
         6:
         begin
            ins[14:12] = OPMVX;
            ins[31:26] = {3'b101, lo};
         end
         7: ins[14:12] = OPCFG;
         default:
         begin
            // slide up or down
            ins[14:12] = lo[1] ? OPIVX : OPIVI;
            ins[31:26] = {5'b00111, lo[0]};
         end
      endcase
      return ins;
   endfunction

   function automatic word_t mem_instr(input logic [6:0] op, input logic [1:0] mp,
                                       input width_t w);
      word_t ins;
      ins = $urandom;
      ins[31:28] = 4'b0000;
      ins[27:26] = mp;
      ins[14:12] = w;
      ins[6:0]   = op;
      return ins;
   endfunction

   task automatic expect_issue(input int lane, input word_t ins, input word_t rs1);
      exp_lane.push_back(lane);
      exp_instr.push_back(ins);
      exp_rs1.push_back(rs1);
   endtask

   task automatic expect_access(input logic we, input word_t base, input word_t step);
      for (int k = 0; k < VLEN_ELEMS; k++)
      begin
         exp_mem.push_back({we, base + word_t'(k) * step});
      end
      if (!we)
      begin
         reads_pushed += VLEN_ELEMS;
         load_marks.push_back(reads_pushed);
      end
   endtask

   // record what the instruction must produce, then hold it until taken
   task automatic send_instr(input word_t ins, input word_t a, input word_t b, input sew_t s);
      int    lane;
      logic  by_mcu;
      word_t step;
      word_t part2;
      logic  taken;
      lane   = expected_lane(ins);
      by_mcu = (ins[27:26] == unit_stride) || (ins[27:26] == strided);
      step   = (ins[27:26] == strided) ? b : elem_size(ins[14:12]);
      if (ins[6:0] == v_ld_opcode && by_mcu)
      begin
         expect_access(1'b0, a, step);
         expect_issue(lane, ins, a);
      end
      else if (ins[6:0] == v_st_opcode && by_mcu)
      begin
         expect_issue(lane, ins, a);
         expect_access(1'b1, a, step);
      end
      else if (ins[6:0] == v_ld_opcode && ins[27:26] == idx_unordered)
      begin
         part2 = ins;
         part2[27:26] = unit_stride;
         part2[14:12] = load_width(s);
         expect_issue(lane, ins, a);
         expect_access(1'b0, a, elem_size(part2[14:12]));
         expect_issue(4, part2, a);
      end
      else if (lane >= 0)
      begin
         expect_issue(lane, ins, a);
      end
      vector_instr_i = ins;
      rs1_i = a;
      rs2_i = b;
      sew_i = s;
      taken = 1'b0;
      while (!taken)
      begin
         // stall is settled one ns before the edge
         #2;
         taken = !vector_stall_o;
         @(posedge clk);
         #1;
      end
   endtask

   task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
      assert (got === exp)
      else
      begin
         $display("ERROR %s: got 0x%08h, expected 0x%08h", name, got, exp);
         errors++;
      end
   endtask

   task automatic check_issue();
      int    lane;
      word_t ins;
      word_t rs1;
      int    mark;
      if (exp_lane.size() == 0)
      begin
         $display("an issue appeared with no instruction outstanding");
         errors++;
         return;
      end
      lane = exp_lane.pop_front();
      ins  = exp_instr.pop_front();
      rs1  = exp_rs1.pop_front();
      check_value("issue_lane_o", 32'(issue_lane_o), 32'(lane));
      check_value("issue_instr_o", issue_instr_o, ins);
      check_value("issue_rs1_o", issue_rs1_o, rs1);
      issues_seen++;
      if (lane == 4)
      begin
         mark = (load_marks.size() != 0) ? load_marks.pop_front() : -1;
         assert (reads_seen == mark)
         else
         begin
            $display("a load issued after %0d reads, before its reads were done", reads_seen);
            errors++;
         end
      end
   endtask

   task automatic check_mem();
      logic [32:0] exp;
      if (exp_mem.size() == 0)
      begin
         $display("a memory request appeared with no access outstanding");
         errors++;
         return;
      end
      exp = exp_mem.pop_front();
      check_value("mem_we_o", 32'(mem_we_o), 32'(exp[32]));
      check_value("mem_addr_o", mem_addr_o, exp[31:0]);
      mem_seen++;
      if (!mem_we_o)
      begin
         reads_seen++;
      end
   endtask

   // outputs are registered, so the falling edge sees them settled
   always @(negedge clk)
   begin
      if (rstn)
      begin
         if (issue_vld_o)
         begin
            check_issue();
         end
         if (mem_req_o)
         begin
            check_mem();
         end
      end
   end

   initial
   begin
      width_t w;
      int     sva_fails;
      rstn           = 1'b0;
      vector_instr_i = '0;
      rs1_i          = '0;
      rs2_i          = '0;
      sew_i          = '0;
      void'($urandom(32'hfefc1dfd));
      repeat (8) @(posedge clk);
      #1;
      rstn = 1'b1;

      // arithmetic, each followed by a bubble
      for (int i = 0; i < N_ARITH; i++)
      begin
         send_instr(random_arith(), $urandom, $urandom, 2'($urandom));
         send_instr('0, '0, '0, sew_i);
      end

      // unit-stride and strided loads, then stores
      for (int i = 0; i < 8; i++)
      begin
         w = 3'($urandom);
         send_instr(mem_instr((i < 4) ? v_ld_opcode : v_st_opcode,
                              i[0] ? strided : unit_stride, w),
                    $urandom, $urandom, 2'($urandom));
      end

      // split loads, the bubble keeps sew until the second part is held
      for (int s = 0; s < 4; s++)
      begin
         w = 3'($urandom);
         send_instr(mem_instr(v_ld_opcode, idx_unordered, w), $urandom, $urandom, sew_t'(s));
         send_instr('0, '0, '0, sew_t'(s));
      end

      // index-only lanes
      send_instr(mem_instr(v_ld_opcode, idx_ordered, 3'd6), $urandom, $urandom, 2'd2);
      send_instr(mem_instr(v_st_opcode, idx_ordered, 3'd5), $urandom, $urandom, 2'd1);

      // presented every cycle, held by the stall
      for (int i = 0; i < N_B2B; i++)
      begin
         send_instr(random_arith(), $urandom, $urandom, 2'($urandom));
      end
      send_instr('0, '0, '0, sew_i);

      while (exp_lane.size() != 0 || exp_mem.size() != 0)
      begin
         @(posedge clk);
      end
      repeat (EXEC_LAT + VLEN_ELEMS + 2) @(posedge clk);

      sva_fails = u_vector_issue_top.u_vector_issue_sva.fail_count;
      $display("issues checked %0d, memory requests checked %0d, errors %0d, assertion fails %0d",
               issues_seen, mem_seen, errors, sva_fails);
      if (errors == 0 && sva_fails == 0)
      begin
         $display("TEST RESULT: PASS");
      end
      else
      begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

   // watchdog
   initial
   begin
      cycles = 0;
      while (cycles < MAX_CYCLES)
      begin
         @(posedge clk);
         cycles++;
      end
      $display("timeout after %0d cycles with %0d issues and %0d requests still expected",
               cycles, exp_lane.size(), exp_mem.size());
      $display("TEST RESULT: FAIL");
      $finish;
   end

endmodule

`default_nettype wire

// File: verif/vector_issue_sva.sv
// concurrent checks bound to the issue front end top level
// reset quiet, lane range, execution gap and input hold
`timescale 1ns/1ps
`default_nettype none

module vector_issue_sva
#(
   parameter int EXEC_LAT = 3
)
(
   input logic               clk,
   input logic               rstn,
   input vector_pkg::word_t  vector_instr_i,
   input vector_pkg::word_t  rs1_i,
   input vector_pkg::sew_t   sew_i,
   input logic               vector_stall_i,
   input logic               issue_vld_i,
   input logic [3:0]         issue_lane_i,
   input logic               mem_req_i
);

   // number of failed assertions
   int fail_count = 0;

   a_reset_quiet: assert property (@(posedge clk)
      !rstn |=> !vector_stall_i && !issue_vld_i && !mem_req_i)
      else
      begin
         $error("outputs active right after reset");
         fail_count++;
      end

   a_lane_range: assert property (@(posedge clk) disable iff (!rstn)
      issue_vld_i |-> issue_lane_i < 4'd13)
      else
      begin
         $error("issue lane number out of range");
         fail_count++;
      end

   // shared pipeline stays busy between issues
   a_exec_gap: assert property (@(posedge clk) disable iff (!rstn)
      issue_vld_i |=> !issue_vld_i [*EXEC_LAT])
      else
      begin
         $error("issue inside the execution busy window");
         fail_count++;
      end

   a_hold_inputs: assert property (@(posedge clk) disable iff (!rstn)
      vector_stall_i |=> $stable(vector_instr_i) && $stable(rs1_i) && $stable(sew_i))
      else
      begin
         $error("scalar inputs changed while stalled");
         fail_count++;
      end

endmodule

bind vector_issue_top vector_issue_sva #(.EXEC_LAT(EXEC_LAT)) u_vector_issue_sva
(
   .clk            (clk),
   .rstn           (rstn),
   .vector_instr_i (vector_instr_i),
   .rs1_i          (rs1_i),
   .sew_i          (sew_i),
   .vector_stall_i (vector_stall_o),
   .issue_vld_i    (issue_vld_o),
   .issue_lane_i   (issue_lane_o),
   .mem_req_i      (mem_req_o)
);

`default_nettype wire

// File: verilog/vector_issue_top.sv
// vector issue front end top level
// scheduler feeding v_cu and m_cu
`timescale 1ns/1ps
`default_nettype none

module vector_issue_top
#(
   parameter int EXEC_LAT   = 3,
   parameter int VLEN_ELEMS = 4
)
(
   input  logic               clk,
   input  logic               rstn,
   input  vector_pkg::word_t  vector_instr_i,
   input  vector_pkg::word_t  rs1_i,
   input  vector_pkg::word_t  rs2_i,
   input  vector_pkg::sew_t   sew_i,
   output logic               vector_stall_o,
   output logic               issue_vld_o,
   output logic [3:0]         issue_lane_o,
   output vector_pkg::word_t  issue_instr_o,
   output vector_pkg::word_t  issue_rs1_o,
   output logic               mem_req_o,
   output logic               mem_we_o,
   output vector_pkg::word_t  mem_addr_o
);

   import vector_pkg::*;

   // scheduler to v_cu
   lane_t  instr_vld;
   lane_t  instr_rdy;
   word_t  vector_instr;
   word_t  scalar_rs1;
   word_t  scalar_rs2;

   // scheduler to m_cu
   logic   mcu_ld_vld;
   logic   mcu_ld_rdy;
   logic   mcu_ld_buffered;
   logic   mcu_st_vld;
   logic   mcu_st_rdy;
   word_t  mcu_base_addr;
   word_t  mcu_stride;
   width_t mcu_data_width;
   logic   mcu_strided;

   scheduler u_scheduler
   (
      .clk               (clk),
      .rstn              (rstn),
      .vector_instr_i    (vector_instr_i),
      .rs1_i             (rs1_i),
      .rs2_i             (rs2_i),
      .sew_i             (sew_i),
      .vector_stall_o    (vector_stall_o),
      .instr_rdy_i       (instr_rdy),
      .instr_vld_o       (instr_vld),
      .vector_instr_o    (vector_instr),
      .scalar_rs1_o      (scalar_rs1),
      .scalar_rs2_o      (scalar_rs2),
      .mcu_ld_rdy_i      (mcu_ld_rdy),
      .mcu_ld_buffered_i (mcu_ld_buffered),
      .mcu_st_rdy_i      (mcu_st_rdy),
      .mcu_ld_vld_o      (mcu_ld_vld),
      .mcu_st_vld_o      (mcu_st_vld),
      .mcu_base_addr_o   (mcu_base_addr),
      .mcu_stride_o      (mcu_stride),
      .mcu_data_width_o  (mcu_data_width),
      .mcu_strided_o     (mcu_strided)
   );

   v_cu #(.EXEC_LAT(EXEC_LAT)) u_v_cu
   (
      .clk            (clk),
      .rstn           (rstn),
      .instr_vld_i    (instr_vld),
      .vector_instr_i (vector_instr),
      .scalar_rs1_i   (scalar_rs1),
      .scalar_rs2_i   (scalar_rs2),
      .instr_rdy_o    (instr_rdy),
      .issue_vld_o    (issue_vld_o),
      .issue_lane_o   (issue_lane_o),
      .issue_instr_o  (issue_instr_o),
      .issue_rs1_o    (issue_rs1_o)
   );

   m_cu #(.VLEN_ELEMS(VLEN_ELEMS)) u_m_cu
   (
      .clk               (clk),
      .rstn              (rstn),
      .mcu_ld_vld_i      (mcu_ld_vld),
      .mcu_st_vld_i      (mcu_st_vld),
      .mcu_base_addr_i   (mcu_base_addr),
      .mcu_stride_i      (mcu_stride),
      .mcu_data_width_i  (mcu_data_width),
      .mcu_strided_i     (mcu_strided),
      .mcu_ld_rdy_o      (mcu_ld_rdy),
      .mcu_st_rdy_o      (mcu_st_rdy),
      .mcu_ld_buffered_o (mcu_ld_buffered),
      .mem_req_o         (mem_req_o),
      .mem_we_o          (mem_we_o),
      .mem_addr_o        (mem_addr_o)
   );

endmodule

`default_nettype wire

// File: verilog/m_cu.sv
// memory control unit
// load/store FSM stepping through the elements of one access
// emits address requests and the load buffered pulse
`timescale 1ns/1ps
`default_nettype none

module m_cu
#(
   parameter int VLEN_ELEMS = 4
)
(
   input  logic                clk,
   input  logic                rstn,
   input  logic                mcu_ld_vld_i,
   input  logic                mcu_st_vld_i,
   input  vector_pkg::word_t   mcu_base_addr_i,
   input  vector_pkg::word_t   mcu_stride_i,
   input  vector_pkg::width_t  mcu_data_width_i,
   input  logic                mcu_strided_i,
   output logic                mcu_ld_rdy_o,
   output logic                mcu_st_rdy_o,
   output logic                mcu_ld_buffered_o,
   output logic                mem_req_o,
   output logic                mem_we_o,
   output vector_pkg::word_t   mem_addr_o
);

   import vector_pkg::*;

   localparam int CNT_W = (VLEN_ELEMS > 1) ? $clog2(VLEN_ELEMS) : 1;

   mcu_state_e       state_q;
   logic [CNT_W-1:0] elem_cnt;
   logic             last_elem;
   logic             buffered_q;
   word_t            elem_bytes;
   word_t            elem_step;
   word_t            step_q;
   word_t            addr_q;

   // element size in bytes from the width code
   always_comb
   begin
      case (mcu_data_width_i)
         3'b101:  elem_bytes = 32'd2;
         3'b110:  elem_bytes = 32'd4;
         3'b111:  elem_bytes = 32'd8;
         default: elem_bytes = 32'd1;
      endcase
   end

   assign elem_step = mcu_strided_i ? mcu_stride_i : elem_bytes;

   assign mcu_ld_rdy_o = (state_q == idle);
   assign mcu_st_rdy_o = (state_q == idle);
   assign last_elem    = (elem_cnt == CNT_W'(VLEN_ELEMS - 1));

   always_ff @(posedge clk)
   begin
      if (!rstn)
      begin
         state_q    <= idle;
         elem_cnt   <= '0;
         buffered_q <= 1'b0;
      end
      else
      begin
         buffered_q <= 1'b0;
         case (state_q)
            idle:
            begin
               elem_cnt <= '0;
               if (mcu_ld_vld_i)
               begin
                  state_q <= loading;
               end
               else if (mcu_st_vld_i)
               begin
                  state_q <= storing;
               end
            end
            loading, storing:
            begin
               elem_cnt <= elem_cnt + 1'b1;
               if (last_elem)
               begin
                  state_q <= idle;
                  // pulse follows the last read
                  buffered_q <= (state_q == loading);
               end
            end
            default: state_q <= idle;
         endcase
      end
   end

   // descriptor tracks the inputs while idle, so the accept cycle is latched
   always_ff @(posedge clk)
   begin
      if (state_q == idle)
      begin
         addr_q <= mcu_base_addr_i;
         step_q <= elem_step;
      end
      else
      begin
         addr_q <= addr_q + step_q;
      end
   end

   assign mem_req_o         = (state_q != idle);
   assign mem_we_o          = (state_q == storing);
   assign mem_addr_o        = addr_q;
   assign mcu_ld_buffered_o = buffered_q;

endmodule

`default_nettype wire

// File: verilog/v_cu.sv
// vector control unit model
// one shared execution pipeline with a busy counter
// lane-ready generation and a one-cycle registered issue record
`timescale 1ns/1ps
`default_nettype none

module v_cu
#(
   parameter int EXEC_LAT = 3
)
(
   input  logic               clk,
   input  logic               rstn,
   input  vector_pkg::lane_t  instr_vld_i,
   input  vector_pkg::word_t  vector_instr_i,
   input  vector_pkg::word_t  scalar_rs1_i,
   input  vector_pkg::word_t  scalar_rs2_i,
   output vector_pkg::lane_t  instr_rdy_o,
   output logic               issue_vld_o,
   output logic [3:0]         issue_lane_o,
   output vector_pkg::word_t  issue_instr_o,
   output vector_pkg::word_t  issue_rs1_o
);

   import vector_pkg::*;

   localparam int CNT_W = (EXEC_LAT > 0) ? $clog2(EXEC_LAT + 1) : 1;

   logic [CNT_W-1:0] busy_cnt;
   logic             exec_idle;
   logic             fire;
   logic [3:0]       lane_num;

   // every lane shares the pipeline
   assign exec_idle   = (busy_cnt == '0);
   assign instr_rdy_o = exec_idle ? '1 : '0;
   assign fire        = (instr_vld_i & instr_rdy_o) != '0;

   // one-hot to lane number
   always_comb
   begin
      lane_num = '0;
      for (int i = 0; i < $bits(lane_t); i++)
      begin
         if (instr_vld_i[i])
         begin
            lane_num = 4'(i);
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (!rstn)
      begin
         busy_cnt <= '0;
      end
      else if (fire)
      begin
         busy_cnt <= CNT_W'(EXEC_LAT);
      end
      else if (!exec_idle)
      begin
         busy_cnt <= busy_cnt - 1'b1;
      end
   end

   always_ff @(posedge clk)
   begin
      if (!rstn)
      begin
         issue_vld_o <= 1'b0;
      end
      else
      begin
         issue_vld_o <= fire;
      end
   end

   // issue record payload
   always_ff @(posedge clk)
   begin
      if (fire)
      begin
         issue_lane_o  <= lane_num;
         issue_instr_o <= vector_instr_i;
         issue_rs1_o   <= scalar_rs1_i;
      end
   end

endmodule

`default_nettype wire

// File: verilog/scheduler.sv
// issue scheduler: holds one vector instruction and decodes it to a v_cu lane
// drives the m_cu load/store handshakes and the scalar-side stall
// splits unordered indexed loads into an index issue and a unit-stride load
`timescale 1ns/1ps
`default_nettype none

module scheduler
(
   input  logic                clk,
   input  logic                rstn,
   // scalar side
   input  vector_pkg::word_t   vector_instr_i,
   input  vector_pkg::word_t   rs1_i,
   input  vector_pkg::word_t   rs2_i,
   input  vector_pkg::sew_t    sew_i,
   output logic                vector_stall_o,
   // v_cu side
   input  vector_pkg::lane_t   instr_rdy_i,
   output vector_pkg::lane_t   instr_vld_o,
   output vector_pkg::word_t   vector_instr_o,
   output vector_pkg::word_t   scalar_rs1_o,
   output vector_pkg::word_t   scalar_rs2_o,
   // m_cu side
   input  logic                mcu_ld_rdy_i,
   input  logic                mcu_ld_buffered_i,
   input  logic                mcu_st_rdy_i,
   output logic                mcu_ld_vld_o,
   output logic                mcu_st_vld_o,
   output vector_pkg::word_t   mcu_base_addr_o,
   output vector_pkg::word_t   mcu_stride_o,
   output vector_pkg::width_t  mcu_data_width_o,
   output logic                mcu_strided_o
);

   import vector_pkg::*;

   word_t      instr_q;
   word_t      rs1_q;
   word_t      rs2_q;
   word_t      idx_ld_part2;
   width_t     sew_width;

   logic [6:0] opcode;
   logic [2:0] funct3;
   logic [5:0] funct6;
   logic [1:0] mop;

   logic       is_ld;
   logic       is_st;
   logic       is_arith;
   logic       mem_mop;
   logic       split_ld;

   lane_t      lane_dec;
   logic       ld_hold;
   logic       st_hold;
   logic       lane_fire;
   logic       advance;

   logic       ld_buffering_q;
   logic       ld_buffered_q;

   // instruction fields
   assign opcode = instr_q[6:0];
   assign funct3 = instr_q[14:12];
   assign funct6 = instr_q[31:26];
   assign mop    = instr_q[27:26];

   assign is_ld    = (opcode == v_ld_opcode);
   assign is_st    = (opcode == v_st_opcode);
   assign is_arith = (opcode == v_arith_opcode);

   // unit-stride and strided accesses go through m_cu
   assign mem_mop  = (mop == unit_stride) || (mop == strided);
   assign split_ld = is_ld && (mop == idx_unordered);

   // lane decode, ungated
   always_comb
   begin
      lane_dec = '0;
      if (is_st)
      begin
         lane_dec = mem_mop ? STORE_vld : STORE_IDX_vld;
      end
      else if (is_ld)
      begin
         lane_dec = mem_mop ? LOAD_vld : LOAD_IDX_vld;
      end
      else if (is_arith)
      begin
         if (funct3 != OPCFG && (funct6 == 6'b001110 || funct6 == 6'b001111))
         begin
            // vslideup / vslidedown family
            lane_dec = SLIDE_vld;
         end
         else
         begin
            case (funct3)
               OPIVV: lane_dec = OPIVV_vld;
               OPIVI: lane_dec = OPIVI_vld;
               OPIVX: lane_dec = OPIVX_vld;
               OPMVV: lane_dec = (funct6[5:3] == 3'b101) ? OPMVV_101xxx_vld : OPMVV_vld;
               OPMVX: lane_dec = (funct6[5:3] == 3'b101) ? OPMVX_101xxx_vld : OPMVX_vld;
               OPCFG: lane_dec = OPCFG_vld;
               // no floating point lanes
               OPFVV, OPFVF: lane_dec = '0;
               default: lane_dec = '0;
            endcase
         end
      end
   end

   // a load waits for its buffered data, a store for a free m_cu
   assign ld_hold     = is_ld && mem_mop && !ld_buffered_q;
   assign st_hold     = is_st && mem_mop && !mcu_st_rdy_i;
   assign instr_vld_o = (ld_hold || st_hold) ? '0 : lane_dec;

   assign lane_fire = (instr_vld_o & instr_rdy_i) != '0;
   // bubbles and undecoded opcodes leave right away
   assign advance   = (lane_dec == '0) || lane_fire;

   // second half of the split consumes a slot, so the scalar side waits
   assign vector_stall_o = !advance || split_ld;

   // m_cu handshakes
   assign mcu_ld_vld_o = is_ld && mem_mop && !ld_buffering_q && !ld_buffered_q;
   assign mcu_st_vld_o = is_st && mem_mop && ((instr_rdy_i & STORE_vld) != '0);

   always_ff @(posedge clk)
   begin
      if (!rstn)
      begin
         ld_buffering_q <= 1'b0;
      end
      else if (mcu_ld_vld_o && mcu_ld_rdy_i)
      begin
         ld_buffering_q <= 1'b1;
      end
      else if (mcu_ld_buffered_i)
      begin
         ld_buffering_q <= 1'b0;
      end
   end

   // held until the LOAD lane issues
   always_ff @(posedge clk)
   begin
      if (!rstn)
      begin
         ld_buffered_q <= 1'b0;
      end
      else if (mcu_ld_buffered_i)
      begin
         ld_buffered_q <= 1'b1;
      end
      else if (lane_fire && lane_dec == LOAD_vld)
      begin
         ld_buffered_q <= 1'b0;
      end
   end

   // load width code for the current sew
   always_comb
   begin
      case (sew_i)
         2'd0:    sew_width = 3'b000;
         2'd1:    sew_width = 3'b101;
         2'd2:    sew_width = 3'b110;
         default: sew_width = 3'b111;
      endcase
   end

   assign idx_ld_part2 = {instr_q[31:28], unit_stride, instr_q[25:15], sew_width, instr_q[11:0]};

   always_ff @(posedge clk)
   begin
      if (!rstn)
      begin
         instr_q <= '0;
      end
      else if (advance)
      begin
         instr_q <= split_ld ? idx_ld_part2 : vector_instr_i;
      end
   end

   // part two reuses the operands of part one
   always_ff @(posedge clk)
   begin
      if (advance && !split_ld)
      begin
         rs1_q <= rs1_i;
         rs2_q <= rs2_i;
      end
   end

   assign vector_instr_o   = instr_q;
   assign scalar_rs1_o     = rs1_q;
   assign scalar_rs2_o     = rs2_q;
   assign mcu_base_addr_o  = rs1_q;
   assign mcu_stride_o     = rs2_q;
   assign mcu_data_width_o = funct3;
   assign mcu_strided_o    = (mop == strided);

endmodule

`default_nettype wire

// File: verilog/vector_pkg.sv
// shared definitions for the vector issue front end
// opcodes, funct3 classes, mop codes, lane one-hots and the m_cu state enum
`default_nettype none

package vector_pkg;

   // widths with a meaning
   typedef logic [31:0] word_t;
   typedef logic [12:0] lane_t;
   typedef logic [1:0]  sew_t;
   typedef logic [2:0]  width_t;

   // RVV major opcodes
   localparam logic [6:0] v_ld_opcode    = 7'b0000111;
   localparam logic [6:0] v_st_opcode    = 7'b0100111;
   localparam logic [6:0] v_arith_opcode = 7'b1010111;

   // funct3 classes of the arithmetic opcode
   localparam logic [2:0] OPIVV = 3'b000;
   localparam logic [2:0] OPFVV = 3'b001;
   localparam logic [2:0] OPMVV = 3'b010;
   localparam logic [2:0] OPIVI = 3'b011;
   localparam logic [2:0] OPIVX = 3'b100;
   localparam logic [2:0] OPFVF = 3'b101;
   localparam logic [2:0] OPMVX = 3'b110;
   localparam logic [2:0] OPCFG = 3'b111;

   // memory addressing modes
   localparam logic [1:0] unit_stride   = 2'b00;
   localparam logic [1:0] idx_unordered = 2'b01;
   localparam logic [1:0] strided       = 2'b10;
   localparam logic [1:0] idx_ordered   = 2'b11;

   // one-hot v_cu lanes
   localparam lane_t OPIVV_vld        = lane_t'(1) << 0;
   localparam lane_t OPIVI_vld        = lane_t'(1) << 1;
   localparam lane_t STORE_vld        = lane_t'(1) << 2;
   localparam lane_t STORE_IDX_vld    = lane_t'(1) << 3;
   localparam lane_t LOAD_vld         = lane_t'(1) << 4;
   localparam lane_t LOAD_IDX_vld     = lane_t'(1) << 5;
   localparam lane_t OPIVX_vld        = lane_t'(1) << 6;
   localparam lane_t OPMVV_vld        = lane_t'(1) << 7;
   localparam lane_t OPMVX_vld        = lane_t'(1) << 8;
   localparam lane_t OPMVV_101xxx_vld = lane_t'(1) << 9;
   localparam lane_t OPMVX_101xxx_vld = lane_t'(1) << 10;
   localparam lane_t OPCFG_vld        = lane_t'(1) << 11;
   localparam lane_t SLIDE_vld        = lane_t'(1) << 12;

   typedef enum logic [1:0] {idle, loading, storing} mcu_state_e;

endpackage

`default_nettype wire
